//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_pixel_pipe
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(VERILATOR) and run $(TOP)"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJDIR)

//--- compile.f
source/vic_timing_pkg.sv
source/vic_video_pkg.sv
source/dot_timing.sv
source/gfx_shifter.sv
source/mode_colorizer.sv
source/sprite_mixer.sv
source/pixel_pipe_top.sv
test/pixel_checker.sv
test/tb_pixel_pipe.sv

//--- source/dot_timing.sv
`timescale 1ns/1ns

module dot_timing (
    input  logic clk_dot4x,
    input  logic rst,
    output logic clk_phi,
    output logic phi_phase_start_15,
    output logic dot_rising_0,
    output vic_timing_pkg::xpos8_t xpos_mod_8,
    output vic_timing_pkg::cycle_t cycle_num
);

    // four ticks per dot
    vic_timing_pkg::tick_t tick;
    // 32 clocks per bus cycle, 16 low and 16 high
    vic_timing_pkg::phase_t phase;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            tick <= '0;
            phase <= '0;
        end else begin
            tick <= tick + 2'd1;
            phase <= phase + 5'd1;
        end
    end

    // strobe on the last tick of each dot
    // first one lands on the fourth clock out of reset
    assign dot_rising_0 = (tick == vic_timing_pkg::tick_last);

    // top bit of the phase count is the phi level
    assign clk_phi = phase[4];
    // last clock of either half, coincides with a dot strobe
    assign phi_phase_start_15 = (phase[3:0] == 4'd15);

    // dot and cycle counters
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            xpos_mod_8 <= '0;
            cycle_num <= '0;
        end else begin
            if (dot_rising_0)
                xpos_mod_8 <= xpos_mod_8 + 3'd1;
            // new cycle at the end of the high phase
            if (phase == vic_timing_pkg::phase_last) begin
                if (cycle_num == vic_timing_pkg::cycles_per_line - 7'd1)
                    cycle_num <= '0;
                else
                    cycle_num <= cycle_num + 7'd1;
            end
        end
    end

endmodule

//--- source/gfx_shifter.sv
`timescale 1ns/1ns

module gfx_shifter #(
    parameter int gfx_delay = 2
) (
    input  logic clk_dot4x,
    input  logic rst,
    input  logic clk_phi,
    input  logic phi_phase_start_15,
    input  logic dot_rising_0,
    input  vic_timing_pkg::xpos8_t xpos_mod_8,
    input  vic_timing_pkg::cycle_t cycle_num,
    input  logic mcm,
    input  logic bmm,
    input  logic ecm,
    input  vic_timing_pkg::xpos8_t xscroll,
    input  vic_video_pkg::gfx_byte_t pixels_read,
    input  vic_video_pkg::char_word_t char_read,
    output logic [1:0] shift_bits,
    output vic_video_pkg::char_word_t char_shifting,
    output logic is_background_pixel1
);

    // capture stage
    vic_video_pkg::gfx_byte_t pixels_cap;
    vic_video_pkg::char_word_t char_cap;
    vic_timing_pkg::xpos8_t xscroll_cap;

    // delay line, last entry feeds the shifter
    vic_video_pkg::gfx_byte_t pixels_dly [gfx_delay];
    vic_video_pkg::char_word_t char_dly [gfx_delay];

    vic_video_pkg::gfx_byte_t pixels_shifting;
    logic shift_pixels;
    logic load_pixels;
    logic ismc;
    logic ismc_next;

    // take the bytes at the end of the low phase
    always_ff @(posedge clk_dot4x) begin
        if (!clk_phi && phi_phase_start_15) begin
            pixels_cap <= pixels_read;
            char_cap <= char_read;
        end
    end

    // fine scroll only picked up inside the visible cycles
    always_ff @(posedge clk_dot4x) begin
        if (rst)
            xscroll_cap <= '0;
        else if (!clk_phi && phi_phase_start_15 &&
                 cycle_num >= vic_timing_pkg::first_visible_cycle &&
                 cycle_num <= vic_timing_pkg::last_visible_cycle)
            xscroll_cap <= xscroll;
    end

    // one slot per dot
    always_ff @(posedge clk_dot4x) begin
        if (dot_rising_0) begin
            pixels_dly[0] <= pixels_cap;
            char_dly[0] <= char_cap;
            for (int n = gfx_delay - 1; n > 0; n--) begin
                pixels_dly[n] <= pixels_dly[n - 1];
                char_dly[n] <= char_dly[n - 1];
            end
        end
    end

    assign load_pixels = (xpos_mod_8 == xscroll_cap);

    // multicolor for the byte in the shifter and for the one about to load
    assign ismc = mcm & (bmm | ecm | char_shifting[11]);
    assign ismc_next = mcm & (bmm | ecm | char_dly[gfx_delay - 1][11]);

    // char word held for the whole cell
    always_ff @(posedge clk_dot4x) begin
        if (dot_rising_0 && load_pixels)
            char_shifting <= char_dly[gfx_delay - 1];
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixels_shifting <= '0;
            shift_pixels <= 1'b0;
            is_background_pixel1 <= 1'b0;
        end else if (dot_rising_0) begin
            if (load_pixels) begin
                pixels_shifting <= pixels_dly[gfx_delay - 1];
                // hires shifts every dot, multicolor holds the first pair
                shift_pixels <= ~ismc_next;
                is_background_pixel1 <= ~pixels_dly[gfx_delay - 1][7];
            end else begin
                // multicolor alternates hold and shift
                if (ismc)
                    shift_pixels <= ~shift_pixels;
                if (shift_pixels && ismc) begin
                    pixels_shifting <= {pixels_shifting[5:0], 2'b00};
                    is_background_pixel1 <= ~pixels_shifting[5];
                end else if (shift_pixels) begin
                    pixels_shifting <= {pixels_shifting[6:0], 1'b0};
                    is_background_pixel1 <= ~pixels_shifting[6];
                end
            end
        end
    end

    assign shift_bits = pixels_shifting[7:6];

endmodule

//--- source/mode_colorizer.sv
`timescale 1ns/1ns

module mode_colorizer (
    input  logic clk_dot4x,
    input  logic rst,
    input  logic dot_rising_0,
    input  logic ecm,
    input  logic bmm,
    input  logic mcm,
    input  logic [1:0] shift_bits,
    input  vic_video_pkg::char_word_t char_shifting,
    input  logic is_background_pixel1,
    input  vic_video_pkg::color_t b0c,
    input  vic_video_pkg::color_t b1c,
    input  vic_video_pkg::color_t b2c,
    input  vic_video_pkg::color_t b3c,
    output vic_video_pkg::color_t pixel_color1,
    output logic is_background_pixel2
);

    vic_video_pkg::display_mode_t mode;
    vic_video_pkg::color_t color_next;
    vic_video_pkg::color_t hires_char;
    vic_video_pkg::color_t hires_bitmap;
    vic_video_pkg::color_t mc_bitmap;
    vic_video_pkg::color_t mc_char;
    vic_video_pkg::color_t ecm_char;

    assign mode = vic_video_pkg::display_mode_t'({ecm, bmm, mcm});

    // set pixel takes the colour nibble
    assign hires_char = shift_bits[1] ? char_shifting[11:8] : b0c;

    // both colours come from the screen byte
    assign hires_bitmap = shift_bits[1] ? char_shifting[7:4] : char_shifting[3:0];

    always_comb begin
        case (shift_bits)
            2'b00: mc_bitmap = b0c;
            2'b01: mc_bitmap = char_shifting[7:4];
            2'b10: mc_bitmap = char_shifting[3:0];
            default: mc_bitmap = char_shifting[11:8];
        endcase
    end

    // pair 11 only has three bits of colour
    always_comb begin
        case (shift_bits)
            2'b00: mc_char = b0c;
            2'b01: mc_char = b1c;
            2'b10: mc_char = b2c;
            default: mc_char = {1'b0, char_shifting[10:8]};
        endcase
    end

    // background picked by the top two screen code bits
    always_comb begin
        case ({shift_bits[1], char_shifting[7:6]})
            3'b000: ecm_char = b0c;
            3'b001: ecm_char = b1c;
            3'b010: ecm_char = b2c;
            3'b011: ecm_char = b3c;
            default: ecm_char = char_shifting[11:8];
        endcase
    end

    // illegal modes still decode here, the mixer blanks them
    always_comb begin
        case (mode)
            vic_video_pkg::mode_std_char: color_next = hires_char;
            vic_video_pkg::mode_mc_char:
                color_next = char_shifting[11] ? mc_char : hires_char;
            vic_video_pkg::mode_std_bitmap,
            vic_video_pkg::mode_inv_ecm_std_bitmap: color_next = hires_bitmap;
            vic_video_pkg::mode_mc_bitmap,
            vic_video_pkg::mode_inv_ecm_mc_bitmap: color_next = mc_bitmap;
            vic_video_pkg::mode_ecm_char: color_next = ecm_char;
            default: color_next = char_shifting[11] ? mc_char : ecm_char;
        endcase
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixel_color1 <= vic_video_pkg::color_black;
            is_background_pixel2 <= 1'b0;
        end else if (dot_rising_0) begin
            pixel_color1 <= color_next;
            // one more dot so it meets the latched sprite codes
            is_background_pixel2 <= is_background_pixel1;
        end
    end

endmodule

//--- source/pixel_pipe_top.sv
`timescale 1ns/1ns

module pixel_pipe_top #(
    parameter int num_sprites = 8,
    parameter int gfx_delay = 2
) (
    input  logic clk_dot4x,
    input  logic rst,
    input  vic_video_pkg::gfx_byte_t pixels_read,
    input  vic_video_pkg::char_word_t char_read,
    input  logic ecm,
    input  logic bmm,
    input  logic mcm,
    input  vic_timing_pkg::xpos8_t xscroll,
    input  vic_video_pkg::color_t b0c,
    input  vic_video_pkg::color_t b1c,
    input  vic_video_pkg::color_t b2c,
    input  vic_video_pkg::color_t b3c,
    input  vic_video_pkg::color_t ec,
    input  logic main_border,
    input  logic [2*num_sprites-1:0] sprite_pixels,
    input  logic [num_sprites-1:0] sprite_pri,
    input  logic [num_sprites-1:0] sprite_mmc,
    input  logic [4*num_sprites-1:0] sprite_col,
    input  vic_video_pkg::color_t sprite_mc0,
    input  vic_video_pkg::color_t sprite_mc1,
    output vic_video_pkg::color_t pixel_color,
    output logic dot_rising_0,
    output vic_timing_pkg::xpos8_t xpos_mod_8,
    output vic_timing_pkg::cycle_t cycle_num
);

    // shared timebase
    logic clk_phi;
    logic phi_phase_start_15;

    // shifter to colorizer
    logic [1:0] shift_bits;
    vic_video_pkg::char_word_t char_shifting;
    logic is_background_pixel1;

    // colorizer to mixer
    vic_video_pkg::color_t pixel_color1;
    logic is_background_pixel2;

    dot_timing timing_i (
        .clk_dot4x(clk_dot4x),
        .rst(rst),
        .clk_phi(clk_phi),
        .phi_phase_start_15(phi_phase_start_15),
        .dot_rising_0(dot_rising_0),
        .xpos_mod_8(xpos_mod_8),
        .cycle_num(cycle_num)
    );

    gfx_shifter #(.gfx_delay(gfx_delay)) shifter_i (
        .clk_dot4x(clk_dot4x),
        .rst(rst),
        .clk_phi(clk_phi),
        .phi_phase_start_15(phi_phase_start_15),
        .dot_rising_0(dot_rising_0),
        .xpos_mod_8(xpos_mod_8),
        .cycle_num(cycle_num),
        .mcm(mcm),
        .bmm(bmm),
        .ecm(ecm),
        .xscroll(xscroll),
        .pixels_read(pixels_read),
        .char_read(char_read),
        .shift_bits(shift_bits),
        .char_shifting(char_shifting),
        .is_background_pixel1(is_background_pixel1)
    );

    mode_colorizer colorizer_i (
        .clk_dot4x(clk_dot4x),
        .rst(rst),
        .dot_rising_0(dot_rising_0),
        .ecm(ecm),
        .bmm(bmm),
        .mcm(mcm),
        .shift_bits(shift_bits),
        .char_shifting(char_shifting),
        .is_background_pixel1(is_background_pixel1),
        .b0c(b0c),
        .b1c(b1c),
        .b2c(b2c),
        .b3c(b3c),
        .pixel_color1(pixel_color1),
        .is_background_pixel2(is_background_pixel2)
    );

    sprite_mixer #(.num_sprites(num_sprites)) mixer_i (
        .clk_dot4x(clk_dot4x),
        .rst(rst),
        .dot_rising_0(dot_rising_0),
        .ecm(ecm),
        .bmm(bmm),
        .mcm(mcm),
        .pixel_color1(pixel_color1),
        .is_background_pixel2(is_background_pixel2),
        .sprite_pixels(sprite_pixels),
        .sprite_pri(sprite_pri),
        .sprite_mmc(sprite_mmc),
        .sprite_col(sprite_col),
        .sprite_mc0(sprite_mc0),
        .sprite_mc1(sprite_mc1),
        .main_border(main_border),
        .ec(ec),
        .pixel_color(pixel_color)
    );

endmodule

//--- source/sprite_mixer.sv
`timescale 1ns/1ns

module sprite_mixer #(
    parameter int num_sprites = 8
) (
    input  logic clk_dot4x,
    input  logic rst,
    input  logic dot_rising_0,
    input  logic ecm,
    input  logic bmm,
    input  logic mcm,
    input  vic_video_pkg::color_t pixel_color1,
    input  logic is_background_pixel2,
    input  logic [2*num_sprites-1:0] sprite_pixels,
    input  logic [num_sprites-1:0] sprite_pri,
    input  logic [num_sprites-1:0] sprite_mmc,
    input  logic [4*num_sprites-1:0] sprite_col,
    input  vic_video_pkg::color_t sprite_mc0,
    input  vic_video_pkg::color_t sprite_mc1,
    input  logic main_border,
    input  vic_video_pkg::color_t ec,
    output vic_video_pkg::color_t pixel_color
);

    // sprite codes sampled with the graphics pixel
    vic_video_pkg::sprite_px_t spr_px [num_sprites];
    vic_video_pkg::color_t base_color;
    vic_video_pkg::color_t mixed_color;
    logic illegal_mode;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int n = 0; n < num_sprites; n++)
                spr_px[n] <= vic_video_pkg::sprite_px_none;
        end else if (dot_rising_0) begin
            for (int n = 0; n < num_sprites; n++)
                spr_px[n] <= sprite_pixels[2*n +: 2];
        end
    end

    // ecm together with bmm or mcm
    assign illegal_mode = ecm & (bmm | mcm);
    assign base_color = illegal_mode ? vic_video_pkg::color_black : pixel_color1;

    // highest index first so sprite 0 ends on top
    always_comb begin
        mixed_color = base_color;
        for (int n = num_sprites - 1; n >= 0; n--) begin
            if (!sprite_pri[n] || is_background_pixel2) begin
                if (sprite_mmc[n]) begin
                    case (spr_px[n])
                        vic_video_pkg::sprite_px_mc0: mixed_color = sprite_mc0;
                        vic_video_pkg::sprite_px_own: mixed_color = sprite_col[4*n +: 4];
                        vic_video_pkg::sprite_px_mc1: mixed_color = sprite_mc1;
                        default: mixed_color = mixed_color;
                    endcase
                end else if (spr_px[n][1]) begin
                    mixed_color = sprite_col[4*n +: 4];
                end
            end
            // a behind-graphics sprite uncovers foreground that a lower
            // priority sprite painted over
            if (sprite_pri[n] && !is_background_pixel2 &&
                spr_px[n] != vic_video_pkg::sprite_px_none &&
                (sprite_mmc[n] || spr_px[n][1]))
                mixed_color = base_color;
        end
    end

    // border wins over everything
    always_ff @(posedge clk_dot4x) begin
        if (rst)
            pixel_color <= vic_video_pkg::color_black;
        else if (main_border)
            pixel_color <= ec;
        else
            pixel_color <= mixed_color;
    end

endmodule

//--- source/vic_timing_pkg.sv
package vic_timing_pkg;

    // dot position inside an 8 dot character cell
    typedef logic [2:0] xpos8_t;

    // bus cycle number within a raster line
    typedef logic [6:0] cycle_t;

    // sub-dot tick, four clk_dot4x ticks per dot
    typedef logic [1:0] tick_t;

    // clock count within one phi period, low half then high half
    typedef logic [4:0] phase_t;

    // last tick of a dot, where the dot strobe fires
    localparam tick_t tick_last = 2'd3;

    // last clock of a full phi period
    localparam phase_t phase_last = 5'd31;

    // fine scroll is only taken up inside this window
    localparam cycle_t first_visible_cycle = 7'd15;
    localparam cycle_t last_visible_cycle = 7'd55;

    // pal line length in bus cycles
    localparam cycle_t cycles_per_line = 7'd63;

endpackage

//--- source/vic_video_pkg.sv
package vic_video_pkg;

    // palette index
    typedef logic [3:0] color_t;

    // fetched char word
    // bits 11..8 colour nibble, bits 7..0 screen code or bitmap colours
    typedef logic [11:0] char_word_t;

    // fetched pixel byte
    typedef logic [7:0] gfx_byte_t;

    // current pixel code of one sprite
    typedef logic [1:0] sprite_px_t;

    // {ecm, bmm, mcm}
    typedef enum logic [2:0] {
        mode_std_char = 3'b000,
        mode_mc_char = 3'b001,
        mode_std_bitmap = 3'b010,
        mode_mc_bitmap = 3'b011,
        mode_ecm_char = 3'b100,
        // the three below show black on screen
        mode_inv_ecm_mc_char = 3'b101,
        mode_inv_ecm_std_bitmap = 3'b110,
        mode_inv_ecm_mc_bitmap = 3'b111
    } display_mode_t;

    localparam color_t color_black = 4'd0;

    // sprite codes, 00 is always transparent
    localparam sprite_px_t sprite_px_none = 2'b00;
    // multicolor sprites only
    localparam sprite_px_t sprite_px_mc0 = 2'b01;
    localparam sprite_px_t sprite_px_own = 2'b10;
    localparam sprite_px_t sprite_px_mc1 = 2'b11;

endpackage

//--- test/pixel_checker.sv
`timescale 1ns/1ns

module pixel_checker #(
    parameter int num_sprites = 8
) (
    input  logic clk_dot4x,
    input  logic rst,
    input  logic checking,
    input  vic_video_pkg::color_t pixel_color,
    input  logic dot_rising_0,
    input  vic_timing_pkg::xpos8_t xpos_mod_8,
    input  vic_timing_pkg::cycle_t cycle_num,
    input  vic_video_pkg::gfx_byte_t pixels_read,
    input  vic_video_pkg::char_word_t char_read,
    input  logic ecm,
    input  logic bmm,
    input  logic mcm,
    input  vic_timing_pkg::xpos8_t xscroll,
    input  vic_video_pkg::color_t b0c,
    input  vic_video_pkg::color_t b1c,
    input  vic_video_pkg::color_t b2c,
    input  vic_video_pkg::color_t b3c,
    input  vic_video_pkg::color_t ec,
    input  logic main_border,
    input  logic [2*num_sprites-1:0] sprite_pixels,
    input  logic [num_sprites-1:0] sprite_pri,
    input  logic [num_sprites-1:0] sprite_mmc,
    input  logic [4*num_sprites-1:0] sprite_col,
    input  vic_video_pkg::color_t sprite_mc0,
    input  vic_video_pkg::color_t sprite_mc1,
    output int pixel_errors,
    output int timebase_errors,
    output int pixel_checks,
    output int cycle_wraps
);

    int gap;
    logic have_prev;
    logic was_rst;
    vic_timing_pkg::xpos8_t prev_x;
    vic_timing_pkg::cycle_t prev_cycle;
    vic_timing_pkg::cycle_t want_cycle;
    vic_timing_pkg::xpos8_t k;
    vic_video_pkg::color_t want;

    // colour of pixel k of the held cell
    function automatic vic_video_pkg::color_t expected_color(input logic [2:0] k_in);
        vic_video_pkg::gfx_byte_t shifted;
        vic_video_pkg::color_t gfx;
        vic_video_pkg::color_t c;
        logic [1:0] px;
        logic mc;
        logic [1:0] code;
        logic shown;
        mc = mcm & (bmm | char_read[11]);
        // multicolor holds each pair for two dots
        if (mc)
            shifted = pixels_read << {k_in[2:1], 1'b0};
        else
            shifted = pixels_read << k_in;
        px = mc ? shifted[7:6] : {shifted[7], shifted[7]};
        if (ecm && (bmm || mcm))
            gfx = vic_video_pkg::color_black;
        else if (mc && bmm)
            gfx = (px == 2'b00) ? b0c : (px == 2'b01) ? char_read[7:4] :
                  (px == 2'b10) ? char_read[3:0] : char_read[11:8];
        else if (mc)
            gfx = (px == 2'b00) ? b0c : (px == 2'b01) ? b1c :
                  (px == 2'b10) ? b2c : {1'b0, char_read[10:8]};
        else if (bmm)
            gfx = px[1] ? char_read[7:4] : char_read[3:0];
        else if (px[1])
            gfx = char_read[11:8];
        else if (!ecm)
            gfx = b0c;
        else
            gfx = (char_read[7:6] == 2'd0) ? b0c : (char_read[7:6] == 2'd1) ? b1c :
                  (char_read[7:6] == 2'd2) ? b2c : b3c;
        c = gfx;
        // sprite 0 painted last
        for (int n = num_sprites - 1; n >= 0; n--) begin
            code = sprite_pixels[2*n +: 2];
            shown = sprite_mmc[n] ? (code != 2'b00) : code[1];
            if (shown && (!sprite_pri[n] || !px[1])) begin
                if (sprite_mmc[n] && code == 2'b01)
                    c = sprite_mc0;
                else if (sprite_mmc[n] && code == 2'b11)
                    c = sprite_mc1;
                else
                    c = sprite_col[4*n +: 4];
            end
            if (sprite_pri[n] && px[1] && shown)
                c = gfx;
        end
        return main_border ? ec : c;
    endfunction

    always @(negedge clk_dot4x) begin
        if (rst) begin
            gap = 0;
            have_prev = 1'b0;
            was_rst = 1'b1;
            pixel_errors = 0;
            timebase_errors = 0;
            pixel_checks = 0;
            cycle_wraps = 0;
        end else begin
            if (was_rst && pixel_color !== vic_video_pkg::color_black) begin
                $display("[FAIL] %0t pixel_color expected %0d got %0d", $time,
                         vic_video_pkg::color_black, pixel_color);
                pixel_errors++;
            end
            was_rst = 1'b0;
            gap++;
            if (!dot_rising_0 && gap == 4) begin
                $display("no dot strobe came within 4 clocks at %0t", $time);
                timebase_errors++;
            end
            if (dot_rising_0) begin
                // first strobe also four clocks after reset
                if (gap != 4) begin
                    $display("dot strobe came %0d clocks after the previous one at %0t",
                             gap, $time);
                    timebase_errors++;
                end
                want_cycle = have_prev ? prev_cycle : '0;
                if (have_prev && prev_x == 3'd7)
                    want_cycle = (prev_cycle == 7'd62) ? 7'd0 : prev_cycle + 7'd1;
                if (xpos_mod_8 !== (have_prev ? prev_x + 3'd1 : 3'd0)) begin
                    $display("[FAIL] %0t xpos_mod_8 expected %0d got %0d", $time,
                             have_prev ? prev_x + 3'd1 : 3'd0, xpos_mod_8);
                    timebase_errors++;
                end
                if (cycle_num !== want_cycle) begin
                    $display("[FAIL] %0t cycle_num expected %0d got %0d", $time,
                             want_cycle, cycle_num);
                    timebase_errors++;
                end
                if (have_prev && prev_cycle == 7'd62 && cycle_num == 7'd0)
                    cycle_wraps++;
                prev_x = xpos_mod_8;
                prev_cycle = cycle_num;
                have_prev = 1'b1;
                gap = 0;
                // bit 7 shows two dots after the load
                if (checking) begin
                    k = xpos_mod_8 - xscroll - 3'd2;
                    want = expected_color(k);
                    pixel_checks++;
                    if (pixel_color !== want) begin
                        $display("[FAIL] %0t pixel_color expected %0d got %0d", $time,
                                 want, pixel_color);
                        pixel_errors++;
                    end
                end
            end
        end
    end

endmodule

//--- test/tb_pixel_pipe.sv
`timescale 1ns/1ns

module tb_pixel_pipe;

    localparam int num_sprites = 8;
    localparam int num_scenarios = 24;
    localparam int cells_per_scenario = 72;
    // long enough for the scroll window to come round
    localparam int settle_cells = 28;
    localparam longint timeout_ns = num_scenarios * cells_per_scenario * 32 * 8 + 50000;

    logic clk_dot4x = 1'b0;
    logic rst;
    logic checking;
    vic_video_pkg::gfx_byte_t pixels_read;
    vic_video_pkg::char_word_t char_read;
    logic ecm, bmm, mcm;
    vic_timing_pkg::xpos8_t xscroll;
    vic_video_pkg::color_t b0c, b1c, b2c, b3c, ec, sprite_mc0, sprite_mc1;
    logic main_border;
    logic [2*num_sprites-1:0] sprite_pixels;
    logic [num_sprites-1:0] sprite_pri, sprite_mmc;
    logic [4*num_sprites-1:0] sprite_col;
    vic_video_pkg::color_t pixel_color;
    logic dot_rising_0;
    vic_timing_pkg::xpos8_t xpos_mod_8;
    vic_timing_pkg::cycle_t cycle_num;
    int pixel_errors, timebase_errors, pixel_checks, cycle_wraps;
    int other_errors;
    int seed;

    always #4 clk_dot4x = ~clk_dot4x;

    pixel_pipe_top #(.num_sprites(num_sprites), .gfx_delay(2)) dut_i (.*);

    pixel_checker #(.num_sprites(num_sprites)) checker_i (.*);

    // char11: 0 clear, 1 set, else random
    // sprites: 0 none, 1 random, 2 foreground restore case
    task automatic run_scenario(input logic [2:0] mode, input int char11,
                                input int sprites, input logic border);
        logic [31:0] r_gfx;
        logic [31:0] r_col;
        logic [31:0] r_spr;
        logic [31:0] r_scol;
        vic_video_pkg::char_word_t cw;
        r_gfx = $random(seed);
        r_col = $random(seed);
        r_spr = $random(seed);
        r_scol = $random(seed);
        cw = r_gfx[19:8];
        if (char11 == 0)
            cw[11] = 1'b0;
        else if (char11 == 1)
            cw[11] = 1'b1;
        @(posedge clk_dot4x);
        checking <= 1'b0;
        {ecm, bmm, mcm} <= mode;
        pixels_read <= r_gfx[7:0];
        char_read <= cw;
        xscroll <= r_gfx[22:20];
        {b0c, b1c, b2c, b3c, ec, sprite_mc0, sprite_mc1} <= r_col[27:0];
        main_border <= border;
        sprite_col <= r_scol;
        sprite_pixels <= '0;
        sprite_pri <= '0;
        sprite_mmc <= '0;
        if (sprites == 1) begin
            sprite_pixels <= r_spr[15:0];
            sprite_pri <= r_spr[23:16];
            sprite_mmc <= r_spr[31:24];
        end else if (sprites == 2) begin
            // sprite 1 in front, sprite 0 behind graphics over it
            sprite_pixels <= 16'b0000_0000_0000_1010;
            sprite_pri <= 8'b0000_0001;
        end
        repeat (settle_cells * 32) @(posedge clk_dot4x);
        checking <= 1'b1;
        repeat ((cells_per_scenario - settle_cells) * 32) @(posedge clk_dot4x);
    endtask

    initial begin
        #(timeout_ns);
        $display("timeout: the scenarios did not finish in time");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        seed = 35;
        other_errors = 0;
        rst = 1'b1;
        checking = 1'b0;
        pixels_read = '0;
        char_read = '0;
        {ecm, bmm, mcm} = 3'b000;
        xscroll = '0;
        {b0c, b1c, b2c, b3c, ec, sprite_mc0, sprite_mc1} = '0;
        main_border = 1'b0;
        sprite_pixels = '0;
        sprite_pri = '0;
        sprite_mmc = '0;
        sprite_col = '0;
        repeat (2) @(posedge clk_dot4x);
        rst <= 1'b0;
        // standard char and bitmap
        repeat (3) run_scenario(3'b000, 2, 0, 1'b0);
        repeat (2) run_scenario(3'b010, 2, 0, 1'b0);
        // multicolor
        repeat (2) run_scenario(3'b001, 1, 0, 1'b0);
        run_scenario(3'b001, 0, 0, 1'b0);
        repeat (2) run_scenario(3'b011, 2, 0, 1'b0);
        // extended background, then the illegal ones
        repeat (2) run_scenario(3'b100, 2, 0, 1'b0);
        run_scenario(3'b101, 2, 0, 1'b0);
        run_scenario(3'b110, 2, 0, 1'b0);
        run_scenario(3'b111, 2, 0, 1'b0);
        // sprites
        repeat (2) run_scenario(3'b000, 2, 1, 1'b0);
        run_scenario(3'b001, 1, 1, 1'b0);
        run_scenario(3'b011, 2, 1, 1'b0);
        run_scenario(3'b100, 2, 1, 1'b0);
        run_scenario(3'b000, 2, 2, 1'b0);
        run_scenario(3'b010, 2, 2, 1'b0);
        // border on top
        run_scenario(3'b000, 2, 1, 1'b1);
        run_scenario(3'b011, 2, 1, 1'b1);
        @(posedge clk_dot4x);
        checking <= 1'b0;
        if (cycle_wraps == 0) begin
            $display("cycle_num never wrapped from 62 to 0");
            other_errors++;
        end
        if (pixel_checks == 0) begin
            $display("no pixel was compared");
            other_errors++;
        end
        $display("errors: pixel %0d, timebase %0d, other %0d",
                 pixel_errors, timebase_errors, other_errors);
        if (pixel_errors + timebase_errors + other_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule
